//--- common/exec_macros.svh
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

// Datapath sizing
`define WORD_W      16      // Machine word
`define SHAMT_W     4       // Shift count, log2 of the word width

// Full five-bit opcodes the execute stage decodes itself
`define OP_SLBI     5'b10010  // Shift left and OR in immediate
`define OP_RORI     5'b10110  // Rotate right by immediate
`define OP_BTR      5'b11001  // Bit reverse
`define OP_JR       5'b00101
`define OP_JALR     5'b00111

// Opcode groups, matched on opcode bits [4:2]
`define OP_BR_PFX   3'b011    // BEQZ, BNEZ, BLTZ, BGEZ
`define OP_SET_PFX  3'b111    // SEQ, SLT, SLE, SCO

`endif

//--- common/exec_pkg.sv
`include "exec_macros.svh"

package exec_pkg;

  // One machine word, used for every datapath operand
  typedef logic [`WORD_W-1:0] word_t;

  typedef logic [4:0] instr_op_t;  // Opcode as it leaves decode

  // ALU function select
  // Low two bits double as the shifter mode
  typedef enum logic [2:0] {
    ALU_ROL  = 3'b000,
    ALU_SLL  = 3'b001,
    ALU_ROR  = 3'b010,  // Rewritten to ROL before the ALU
    ALU_SRL  = 3'b011,
    ALU_ADD  = 3'b100,
    ALU_OR   = 3'b101,
    ALU_XOR  = 3'b110,
    ALU_ANDN = 3'b111
  } alu_op_t;

  // Status bits handed to the memory stage
  typedef struct packed {
    logic zero;  // Result is zero
    logic ltz;   // Signed less than zero
    logic err;   // Overflow not masked by pass-through
  } flags_t;

  // Everything the stage register carries, 51 bits
  typedef struct packed {
    word_t  alu_result;
    word_t  branch_target;
    word_t  jump_target;
    flags_t flags;
  } ex_result_t;

endpackage

//--- rtl/adder16.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module adder16 import exec_pkg::*; (
  input  word_t a,
  input  word_t b,
  input  logic  cin,
  input  logic  sign,  // Report signed overflow instead of carry out
  output word_t sum,
  output logic  ofl
);

  logic [`WORD_W:0] carry;  // carry[i] feeds bit i

  // Plain ripple chain, one full adder per bit
  always_comb begin
    carry[0] = cin;
    for (int i = 0; i < `WORD_W; i++) begin
      sum[i]     = a[i] ^ b[i] ^ carry[i];
      carry[i+1] = (a[i] & b[i]) | (carry[i] & (a[i] ^ b[i]));
    end
  end

  // Signed overflow when carries into and out of the MSB differ
  assign ofl = sign ? (carry[`WORD_W] ^ carry[`WORD_W-1]) : carry[`WORD_W];

endmodule

//--- alu/shifter.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module shifter import exec_pkg::*; (
  input  word_t               in_word,
  input  logic [`SHAMT_W-1:0] count,
  input  logic [1:0]          mode,     // 00 ROL, 01 SLL, 11 SRL
  output word_t               out_word
);

  localparam int W = `WORD_W;

  // Stage 0 is the input, stage SHAMT_W the result
  word_t stage [`SHAMT_W+1];

  assign stage[0] = in_word;

  // Log shifter, stage i moves by 2**i when count bit i is set
  for (genvar i = 0; i < `SHAMT_W; i++) begin : g_stage
    localparam int AMT = 1 << i;

    word_t rol_w;
    word_t sll_w;
    word_t srl_w;

    assign rol_w = {stage[i][W-AMT-1:0], stage[i][W-1:W-AMT]};  // Wrap top bits around
    assign sll_w = {stage[i][W-AMT-1:0], {AMT{1'b0}}};
    assign srl_w = {{AMT{1'b0}}, stage[i][W-1:AMT]};           // Zero fill from the top

    always_comb begin
      if (!count[i]) begin
        stage[i+1] = stage[i];  // Bit clear, pass straight on
      end else begin
        case (mode)
          2'b01:   stage[i+1] = sll_w;
          2'b11:   stage[i+1] = srl_w;
          // ROR never gets here as such, execute turns it into ROL
          default: stage[i+1] = rol_w;
        endcase
      end
    end
  end

  assign out_word = stage[`SHAMT_W];

endmodule

//--- alu/alu.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module alu import exec_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  logic    cin,
  input  logic    inv_a,
  input  logic    inv_b,
  input  logic    sign,
  input  alu_op_t op,
  output word_t   result,
  output logic    ofl,
  output logic    zero,
  output logic    ltz
);

  word_t op_a;
  word_t op_b;
  word_t sum;
  word_t shifted;
  logic  add_ofl;     // As the adder reports it, per sign
  logic  signed_ofl;  // Always two's complement, for ltz
  logic  is_add;

  // Optional inversion, SUB is ~B plus cin
  assign op_a = inv_a ? ~a : a;
  assign op_b = inv_b ? ~b : b;

  assign is_add = (op == ALU_ADD);

  adder16 u_adder (
    .a    (op_a),
    .b    (op_b),
    .cin  (cin),
    .sign (sign),
    .sum  (sum),
    .ofl  (add_ofl)
  );

  // Shift amount is only the low bits of B
  shifter u_shifter (
    .in_word  (op_a),
    .count    (op_b[`SHAMT_W-1:0]),
    .mode     (op[1:0]),
    .out_word (shifted)
  );

  // Operands agree in sign but the sum does not
  assign signed_ofl = (op_a[`WORD_W-1] == op_b[`WORD_W-1]) &&
                      (sum[`WORD_W-1] != op_a[`WORD_W-1]);

  always_comb begin
    case (op)
      ALU_ADD:  result = sum;
      ALU_OR:   result = op_a | op_b;
      ALU_XOR:  result = op_a ^ op_b;
      ALU_ANDN: result = op_a & ~op_b;
      default:  result = shifted;  // ROL, SLL, ROR, SRL
    endcase
  end

  assign ofl  = is_add & add_ofl;  // Shifts and logic never overflow
  assign zero = ~|result;

  // True signed less-than, sign bit flipped on overflow
  assign ltz = is_add ? (sum[`WORD_W-1] ^ signed_ofl) : result[`WORD_W-1];

endmodule

//--- execute/execute.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module execute import exec_pkg::*; (
  input  alu_op_t   alu_op,
  input  instr_op_t instr_op,
  input  logic      alu_src,    // Immediate on the B side
  input  logic      inv_a,
  input  logic      inv_b,
  input  logic      cin,
  input  logic      sign,
  input  logic      pass_a,     // Result is read1data
  input  logic      pass_b,     // Result is operand B
  input  logic      mem_write,
  input  word_t     read1data,
  input  word_t     read2data,
  input  word_t     immediate,
  input  word_t     pc,
  input  word_t     jump_in,    // Jump displacement from decode
  output word_t     alu_result,
  output word_t     branch_target,
  output word_t     jump_target,
  output logic      zero,
  output logic      ltz,
  output logic      err
);

  logic    is_rori;
  logic    is_btr;
  logic    is_slbi;
  logic    is_branch;
  logic    is_set;
  logic    is_jump;
  logic    is_ror;
  logic    set_hit;
  logic    alu_ofl;
  logic    branch_ofl;
  alu_op_t alu_op_eff;
  word_t   rot_cnt;
  word_t   rot_neg;
  word_t   alu_a;
  word_t   alu_b;
  word_t   alu_out;
  word_t   btr_word;
  word_t   jump_base;

  // Opcode decode
  assign is_rori   = (instr_op == `OP_RORI);
  assign is_btr    = (instr_op == `OP_BTR);
  assign is_slbi   = (instr_op == `OP_SLBI);
  assign is_branch = (instr_op[4:2] == `OP_BR_PFX);
  assign is_set    = (instr_op[4:2] == `OP_SET_PFX);
  assign is_jump   = (instr_op == `OP_JR) || (instr_op == `OP_JALR);
  assign is_ror    = (alu_op == ALU_ROR);  // ROR and RORI

  // Rotate right by n is rotate left by -n mod 16
  assign rot_cnt    = is_rori ? immediate : read1data;
  assign rot_neg    = ~rot_cnt + 1'b1;
  assign alu_op_eff = is_ror ? ALU_ROL : alu_op;

  // A side
  always_comb begin
    if (is_slbi) begin
      alu_a = read2data << (`WORD_W / 2);  // Low byte moves up, immediate ORs in
    end else if (mem_write) begin
      alu_a = read1data;                   // Store data path
    end else begin
      alu_a = read2data;
    end
  end

  // B side, branches only need the flags of A
  always_comb begin
    if (is_branch) begin
      alu_b = '0;
    end else if (is_ror) begin
      alu_b = rot_neg;
    end else if (alu_src) begin
      alu_b = immediate;
    end else if (mem_write) begin
      alu_b = read2data;
    end else begin
      alu_b = read1data;
    end
  end

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .cin    (cin),
    .inv_a  (inv_a),
    .inv_b  (inv_b),
    .sign   (sign),
    .op     (alu_op_eff),
    .result (alu_out),
    .ofl    (alu_ofl),
    .zero   (zero),
    .ltz    (ltz)
  );

  // BTR mirrors read2data end for end
  always_comb begin
    for (int i = 0; i < `WORD_W; i++) begin
      btr_word[i] = read2data[`WORD_W-1-i];
    end
  end

  // Condition for the set group, chosen by opcode bits [1:0]
  always_comb begin
    case (instr_op[1:0])
      2'b00:   set_hit = zero;         // SEQ
      2'b01:   set_hit = ltz;          // SLT
      2'b10:   set_hit = zero | ltz;   // SLE
      default: set_hit = alu_ofl;      // SCO
    endcase
  end

  // Result select, BTR wins over sets, sets over pass-through
  always_comb begin
    if (is_btr) begin
      alu_result = btr_word;
    end else if (is_set) begin
      alu_result = set_hit ? word_t'(1) : '0;
    end else if (pass_a && !pass_b) begin
      alu_result = read1data;
    end else if (pass_b && !pass_a) begin
      alu_result = alu_b;
    end else begin
      alu_result = alu_out;  // Both or neither pass bit set
    end
  end

  adder16 u_branch_add (
    .a    (pc),
    .b    (immediate),
    .cin  (1'b0),
    .sign (1'b0),  // Unsigned, ofl is the carry out
    .sum  (branch_target),
    .ofl  (branch_ofl)
  );

  // JR and JALR are register relative, other jumps pc relative
  assign jump_base = is_jump ? read2data : pc;

  adder16 u_jump_add (
    .a    (jump_base),
    .b    (jump_in),
    .cin  (1'b0),
    .sign (1'b1),
    .sum  (jump_target),
    .ofl  ()
  );

  assign err = (alu_ofl | branch_ofl) & ~(pass_a | pass_b);

endmodule

//--- rtl/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type T = logic
) (
  input  logic clk,
  input  logic arst_n,
  input  logic in_valid,
  input  logic stall,
  input  T     d,
  output logic out_valid,
  output T     q
);

  // Stall freezes everything, a bubble keeps the old data
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      q         <= '0;  // Outputs read zero out of reset
    end else if (!stall) begin
      out_valid <= in_valid;
      if (in_valid) begin
        q <= d;
      end
    end
  end

endmodule

//--- rtl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit import exec_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      in_valid,
  input  logic      stall,      // Back-pressure from the memory stage
  input  alu_op_t   alu_op,
  input  instr_op_t instr_op,
  input  logic      alu_src,
  input  logic      inv_a,
  input  logic      inv_b,
  input  logic      cin,
  input  logic      sign,
  input  logic      pass_a,
  input  logic      pass_b,
  input  logic      mem_write,
  input  word_t     read1data,
  input  word_t     read2data,
  input  word_t     immediate,
  input  word_t     pc,
  input  word_t     jump_in,
  output logic      out_valid,
  output word_t     alu_result,
  output word_t     branch_target,
  output word_t     jump_target,
  output flags_t    flags
);

  word_t      ex_alu_result;
  word_t      ex_branch_target;
  word_t      ex_jump_target;
  logic       ex_zero;
  logic       ex_ltz;
  logic       ex_err;
  ex_result_t ex_d;  // Combinational results
  ex_result_t ex_q;  // Registered, seen by memory

  execute u_execute (
    .alu_op        (alu_op),
    .instr_op      (instr_op),
    .alu_src       (alu_src),
    .inv_a         (inv_a),
    .inv_b         (inv_b),
    .cin           (cin),
    .sign          (sign),
    .pass_a        (pass_a),
    .pass_b        (pass_b),
    .mem_write     (mem_write),
    .read1data     (read1data),
    .read2data     (read2data),
    .immediate     (immediate),
    .pc            (pc),
    .jump_in       (jump_in),
    .alu_result    (ex_alu_result),
    .branch_target (ex_branch_target),
    .jump_target   (ex_jump_target),
    .zero          (ex_zero),
    .ltz           (ex_ltz),
    .err           (ex_err)
  );

  // Field order follows ex_result_t
  assign ex_d = {ex_alu_result, ex_branch_target, ex_jump_target, ex_zero, ex_ltz, ex_err};

  // One cycle to the memory stage
  pipe_reg #(
    .T (ex_result_t)
  ) u_out_reg (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .stall     (stall),
    .d         (ex_d),
    .out_valid (out_valid),
    .q         (ex_q)
  );

  assign alu_result    = ex_q.alu_result;
  assign branch_target = ex_q.branch_target;
  assign jump_target   = ex_q.jump_target;
  assign flags         = ex_q.flags;

endmodule

//--- bench/exec_unit_asserts.sv
`timescale 1ns/1ps

module exec_unit_asserts import exec_pkg::*; (
  input logic   clk,
  input logic   arst_n,
  input logic   in_valid,
  input logic   stall,
  input logic   pass_a,
  input logic   pass_b,
  input logic   out_valid,
  input word_t  alu_result,
  input word_t  branch_target,
  input word_t  jump_target,
  input flags_t flags
);

  // Nothing leaves the stage while reset is held
  a_reset_no_valid : assert property (@(posedge clk) !arst_n |-> !out_valid)
    else $error("out_valid high during reset");

  // Stall freezes the whole output register one edge later
  a_stall_holds : assert property (@(posedge clk) disable iff (!arst_n)
    stall |=> ($stable(out_valid) && $stable(alu_result) && $stable(branch_target)
               && $stable(jump_target) && $stable(flags)))
    else $error("outputs moved under stall");

  // A pass-through item lands with its err bit clear
  a_pass_masks_err : assert property (@(posedge clk) disable iff (!arst_n)
    (in_valid && !stall && (pass_a || pass_b)) |=> !flags.err)
    else $error("err set with pass-through active");

endmodule

bind exec_unit exec_unit_asserts i_exec_unit_asserts (
  .clk           (clk),
  .arst_n        (arst_n),
  .in_valid      (in_valid),
  .stall         (stall),
  .pass_a        (pass_a),
  .pass_b        (pass_b),
  .out_valid     (out_valid),
  .alu_result    (alu_result),
  .branch_target (branch_target),
  .jump_target   (jump_target),
  .flags         (flags)
);

//--- bench/exec_unit_tb.sv
`timescale 1ns/1ps
`include "exec_macros.svh"

module exec_unit_tb import exec_pkg::*; ();

  localparam int    TIMEOUT = 20;         // Cycles allowed for out_valid
  localparam word_t JIN     = 16'h0010;   // Jump displacement on every row
  localparam word_t PC      = 16'h0100;
  localparam instr_op_t ALU_OPC = 5'b11011;  // Plain ALU instruction
  // Control bits {alu_src, inv_a, inv_b, cin, sign, pass_a, pass_b, mem_write}
  localparam logic [7:0] C_NONE = 8'h00;
  localparam logic [7:0] C_ADD  = 8'h08;  // Signed add
  localparam logic [7:0] C_SUB  = 8'h38;  // A + ~B + 1, signed

  typedef struct {
    alu_op_t    op;
    instr_op_t  iop;
    logic [7:0] ctl;
    word_t      r1, r2, imm, pc;
    logic       stall;
    word_t      exp_res;
    flags_t     exp_fl;
  } row_t;

  logic clk, arst_n, in_valid, stall;
  alu_op_t alu_op;
  instr_op_t instr_op;
  logic alu_src, inv_a, inv_b, cin, sign, pass_a, pass_b, mem_write;
  word_t read1data, read2data, immediate, pc, jump_in;
  logic out_valid, shadow_valid;
  word_t alu_result, branch_target, jump_target, shadow_d, shadow_q;
  flags_t flags;
  row_t rows[$];
  logic [31:0] lfsr = 32'h7af9;
  word_t last_res, last_br, last_jt;
  flags_t last_fl;

  exec_unit i_exec_unit (.*);

  // Shadow of the expected result, same handshake as the DUT register
  pipe_reg #(.T(word_t)) i_shadow (.clk(clk), .arst_n(arst_n), .in_valid(in_valid),
    .stall(stall), .d(shadow_d), .out_valid(shadow_valid), .q(shadow_q));

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  // Galois LFSR, one step per bit taken
  function automatic logic next_bit();
    logic b;
    b    = lfsr[0];
    lfsr = (lfsr >> 1) ^ (b ? 32'h80200003 : 32'h0);
    return b;
  endfunction

  function automatic word_t rand_word();
    word_t w;
    for (int i = 0; i < `WORD_W; i++) w[i] = next_bit();
    return w;
  endfunction

  task automatic fail_now(input string msg);
    $display("Error at %0t: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1, "stopping on first mismatch");
  endtask

  task automatic check_word(input string what, input word_t got, input word_t exp);
    if (got !== exp) fail_now($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_flags(input flags_t got, input flags_t exp);
    if (got !== exp) fail_now($sformatf("flags got %b expected %b", got, exp));
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("%s got %b expected %b", what, got, exp));
  endtask

  task automatic add_row(input alu_op_t op, input instr_op_t iop, input logic [7:0] ctl,
                         input word_t r1, input word_t r2, input word_t imm,
                         input word_t p, input word_t res, input flags_t fl);
    row_t r;
    r = '{op, iop, ctl, r1, r2, imm, p, 1'b0, res, fl};
    rows.push_back(r);
  endtask

  // Random rows, expected values from 17-bit signed arithmetic
  task automatic add_random();
    word_t a, b, x;
    logic [16:0] s;
    for (int i = 0; i < 4; i++) begin
      a = rand_word();
      b = rand_word();
      x = a ^ b;
      add_row(ALU_XOR, ALU_OPC, C_NONE, b, a, 16'h0004, PC, x, '{x == 0, x[15], 1'b0});
      s = {a[15], a} + {b[15], b};
      add_row(ALU_ADD, ALU_OPC, C_ADD, b, a, 16'h0004, PC, s[15:0],
              '{s[15:0] == 0, s[16], s[16] != s[15]});
    end
  endtask

  task automatic build_table();
    row_t r;
    add_row(ALU_ADD, ALU_OPC, C_ADD, 16'h0101, 16'h1234, 4, PC, 16'h1335, 3'b000);
    add_row(ALU_ADD, ALU_OPC, C_SUB, 16'h0005, 16'h0005, 4, PC, 16'h0000, 3'b100);
    add_row(ALU_ADD, ALU_OPC, C_SUB, 16'h0005, 16'h0003, 4, PC, 16'hfffe, 3'b010);
    add_row(ALU_ADD, ALU_OPC, C_ADD, 16'h0001, 16'h7fff, 4, PC, 16'h8000, 3'b001);
    add_row(ALU_OR, ALU_OPC, C_NONE, 16'h0f00, 16'h00f0, 4, PC, 16'h0ff0, 3'b000);
    add_row(ALU_XOR, ALU_OPC, C_NONE, 16'h0ff0, 16'hff00, 4, PC, 16'hf0f0, 3'b010);
    add_row(ALU_ANDN, ALU_OPC, C_NONE, 16'h00ff, 16'hffff, 4, PC, 16'hff00, 3'b010);
    add_row(ALU_ROL, ALU_OPC, C_NONE, 16'h0001, 16'h8001, 4, PC, 16'h0003, 3'b000);
    add_row(ALU_SLL, ALU_OPC, C_NONE, 16'h0004, 16'h00ff, 4, PC, 16'h0ff0, 3'b000);
    add_row(ALU_SRL, ALU_OPC, C_NONE, 16'h000c, 16'hf000, 4, PC, 16'h000f, 3'b000);
    add_row(ALU_ROR, ALU_OPC, C_NONE, 16'h0001, 16'h0001, 4, PC, 16'h8000, 3'b010);
    add_row(ALU_ROR, `OP_RORI, C_NONE, 16'h0000, 16'h1234, 4, PC, 16'h4123, 3'b000);
    // Held row: new inputs offered under stall must not land
    r = '{ALU_OR, ALU_OPC, C_NONE, 16'hdead, 16'hbeef, 4, PC, 1'b1, 16'h0, 3'b000};
    rows.push_back(r);
    add_row(ALU_OR, `OP_SLBI, 8'h80, 16'h0000, 16'h12ab, 16'h00cd, PC, 16'habcd, 3'b010);
    add_row(ALU_ADD, `OP_BTR, C_ADD, 16'h0000, 16'h0001, 4, PC, 16'h8000, 3'b000);
    add_row(ALU_ADD, ALU_OPC, 8'h0c, 16'h5555, 16'h7fff, 4, PC, 16'h5555, 3'b000);
    add_row(ALU_ADD, ALU_OPC, 8'h8a, 16'h0000, 16'h7fff, 16'h0042, PC, 16'h0042, 3'b000);
    add_row(ALU_ADD, 5'b11100, C_SUB, 16'h0007, 16'h0007, 4, PC, 16'h0001, 3'b100);  // SEQ
    add_row(ALU_ADD, 5'b11101, C_SUB, 16'h0007, 16'h0002, 4, PC, 16'h0001, 3'b010);  // SLT
    add_row(ALU_ADD, 5'b11110, C_SUB, 16'h0007, 16'h0009, 4, PC, 16'h0000, 3'b000);  // SLE
    add_row(ALU_ADD, 5'b11111, C_ADD, 16'h0001, 16'h7fff, 4, PC, 16'h0001, 3'b001);  // SCO
    add_row(ALU_ADD, 5'b01100, C_ADD, 16'h0033, 16'h0000, 16'h0020, PC, 16'h0000, 3'b100);
    add_row(ALU_ADD, ALU_OPC, C_ADD, 16'h0001, 16'h0001, 16'h0020, 16'hfff0, 16'h0002, 3'b001);
    add_row(ALU_ADD, `OP_JR, C_ADD, 16'h0000, 16'h0200, 4, PC, 16'h0200, 3'b000);
    add_row(ALU_ADD, `OP_JALR, C_ADD, 16'h0000, 16'h0300, 4, PC, 16'h0300, 3'b000);
    // ST address, A comes from read1data
    add_row(ALU_ADD, 5'b10000, 8'h89, 16'h1000, 16'h5555, 4, PC, 16'h1004, 3'b000);
    add_random();
  endtask

  task automatic drive(input row_t r);
    {alu_src, inv_a, inv_b, cin, sign, pass_a, pass_b, mem_write} = r.ctl;
    alu_op    = r.op;
    instr_op  = r.iop;
    read1data = r.r1;
    read2data = r.r2;
    immediate = r.imm;
    pc        = r.pc;
    in_valid  = 1'b1;
    stall     = r.stall;
    shadow_d  = r.exp_res;
  endtask

  // Bounded wait, also checks the one-cycle latency
  task automatic wait_valid();
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (!out_valid && n < TIMEOUT);
    if (!out_valid) begin
      $display("Timeout: out_valid never rose within %0d cycles", TIMEOUT);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end else if (n != 1) begin
      fail_now($sformatf("latency %0d cycles, expected 1", n));
    end
  endtask

  initial begin
    row_t r;
    word_t jt;
    arst_n = 1'b0;
    drive('{ALU_ADD, ALU_OPC, C_NONE, 16'h0, 16'h0, 16'h0, 16'h0, 1'b0, 16'h0, 3'b000});
    in_valid = 1'b0;
    jump_in  = JIN;
    build_table();
    repeat (4) @(posedge clk);
    #1;
    check_bit("out_valid in reset", out_valid, 1'b0);
    check_word("alu_result in reset", alu_result, '0);
    check_word("branch_target in reset", branch_target, '0);
    check_word("jump_target in reset", jump_target, '0);
    check_flags(flags, '0);
    arst_n = 1'b1;
    @(posedge clk);
    #1;
    check_bit("out_valid after reset", out_valid, 1'b0);
    foreach (rows[i]) begin
      r = rows[i];
      drive(r);
      wait_valid();
      if (!r.stall) begin
        jt = ((r.iop == `OP_JR) || (r.iop == `OP_JALR)) ? r.r2 : r.pc;
        last_res = r.exp_res;
        last_br  = r.pc + r.imm;  // Branch target rule
        last_jt  = jt + JIN;
        last_fl  = r.exp_fl;
      end
      check_word("alu_result", alu_result, last_res);
      check_bit("shadow_valid", shadow_valid, 1'b1);
      check_word("shadow", shadow_q, last_res);
      check_word("branch_target", branch_target, last_br);
      check_word("jump_target", jump_target, last_jt);
      check_flags(flags, last_fl);
    end
    // Bubble drops valid, data stays
    in_valid = 1'b0;
    stall    = 1'b0;
    @(posedge clk);
    #1;
    check_bit("out_valid on bubble", out_valid, 1'b0);
    check_bit("shadow_valid on bubble", shadow_valid, 1'b0);
    check_word("alu_result on bubble", alu_result, last_res);
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

//--- exec_unit.f
+incdir+common
common/exec_pkg.sv
rtl/adder16.sv
alu/shifter.sv
alu/alu.sv
execute/execute.sv
rtl/pipe_reg.sv
rtl/exec_unit.sv
bench/exec_unit_asserts.sv
bench/exec_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module exec_unit_tb \
  -f exec_unit.f \
  -Mdir obj_dir -o exec_unit_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/exec_unit_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit $status
fi

exit 0
